//--- logic/zports_pkg.sv
/* Port numbers, extension register indices and reset values of the Z80 port block.
   Only the low address byte selects a port; AF registers are indexed by the high byte. */

package zports_pkg;

	typedef logic [7:0] port_t;   // low address byte
	typedef logic [7:0] xt_idx_t; // high address byte at xxAF
	typedef logic [8:0] offs_t;   // scroll offset
	typedef logic [7:0] page_t;   // ram page

	//////////////////////////////
	// port numbers
	//////////////////////////////

	localparam port_t PORT_FE     = 8'hFE; // keyboard in, border out
	localparam port_t PORT_XT     = 8'hAF; // extension registers
	localparam port_t PORT_FD     = 8'hFD; // 7FFD when a15 low, AY when high
	localparam port_t PORT_F7     = 8'hF7; // EFF7
	localparam port_t PORT_BE     = 8'hBE; // config read-back
	localparam port_t PORT_KJOY   = 8'h1F; // kempston joystick
	localparam port_t PORT_KMOUSE = 8'hDF; // kempston mouse

	//////////////////////////////
	// xxAF register indices
	//////////////////////////////

	localparam xt_idx_t XT_VCONF    = 8'h00;
	localparam xt_idx_t XT_VPAGE    = 8'h01;
	localparam xt_idx_t XT_XOFFSL   = 8'h02;
	localparam xt_idx_t XT_XOFFSH   = 8'h03; // bit 0 only
	localparam xt_idx_t XT_YOFFSL   = 8'h04;
	localparam xt_idx_t XT_YOFFSH   = 8'h05; // bit 0 only
	localparam xt_idx_t XT_TSCONF   = 8'h06;
	localparam xt_idx_t XT_BORDER   = 8'h0F;
	localparam xt_idx_t XT_RAMPAGE  = 8'h10; // 10..13
	localparam xt_idx_t XT_ROMPAGE  = 8'h14;
	localparam xt_idx_t XT_FMADDR   = 8'h15;
	localparam xt_idx_t XT_RAMPAGES = 8'h16; // 16..17
	localparam xt_idx_t XT_TGPAGE   = 8'h18;

	//////////////////////////////
	// reset values and widths
	//////////////////////////////

	// windows 0..3, then the two shadow pages
	localparam page_t RAMPAGE_RST [0:5] = '{8'h00, 8'h05, 8'h02, 8'h00, 8'h02, 8'h00};

	localparam page_t VPAGE_RST = 8'h05; // normal screen

	localparam logic [7:0] HIGH_IDLE = 8'hFF; // floating bus

	localparam int PENT_PAGE_W = 6; // 1M page number

endpackage

//--- logic/io_strobe.sv
/* iorq_n, rd_n and wr_n are Z80 levels, sampled on zclk without extra sync stages.
   Each strobe is one zclk wide and fires once per I/O cycle. */

`timescale 1ns/1ps

module io_strobe (
	input  logic zclk,
	input  logic rst_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	output logic port_wr,
	output logic port_rd
);

	logic iowr, iord;
	logic iowr_d, iord_d; // requests seen on the previous edge

	assign iowr = ~(iorq_n | wr_n);
	assign iord = ~(iorq_n | rd_n);

	always_ff @(posedge zclk)
		if (!rst_n)
		begin
			iowr_d  <= 1'b0;
			iord_d  <= 1'b0;
			port_wr <= 1'b0;
			port_rd <= 1'b0;
		end
		else
		begin
			iowr_d  <= iowr;
			iord_d  <= iord;
			port_wr <= iowr & ~iowr_d; // leading edge only
			port_rd <= iord & ~iord_d;
		end

endmodule

//--- logic/port_decode.sv
/* Purely combinational. dos stands in for shadow mode, so 1F and F7 hide while it is high.
   AY accesses on FD with a15 high count as hits but leave the bus to the external chip. */

`timescale 1ns/1ps

module port_decode
	import zports_pkg::*;
(
	input  logic [15:0] a,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        dos,
	input  logic        tape_read,
	input  logic [4:0]  keys_in,
	input  logic [4:0]  kj_in,
	input  logic [7:0]  mus_in,
	input  logic [7:0]  p7ffd,
	input  logic [7:0]  peff7,
	output logic        porthit,
	output logic        external_port,
	output logic        dataout,
	output logic [7:0]  dout
);

	port_t loa;
	logic [7:0] portbe_mux;

	assign loa = a[7:0];

	//////////////////////////////
	// hit decode
	//////////////////////////////

	always_comb
	begin
		case (loa)
			PORT_FE, PORT_XT, PORT_FD, PORT_BE, PORT_KMOUSE:
				porthit = 1'b1;
			PORT_KJOY, PORT_F7:
				porthit = ~dos; // taken by the disk ports in shadow mode
			default:
				porthit = 1'b0;
		endcase
	end

	assign external_port = (loa == PORT_FD) & a[15]; // AY

	assign dataout = porthit & ~iorq_n & ~rd_n & ~external_port;

	//////////////////////////////
	// read-back
	//////////////////////////////

	// BE page select on a[11:8]
	always_comb
	begin
		case (a[11:8])
			4'hA:    portbe_mux = p7ffd;
			4'hB:    portbe_mux = peff7;
			default: portbe_mux = HIGH_IDLE;
		endcase
	end

	always_comb
	begin
		case (loa)
			PORT_FE:     dout = {1'b1, tape_read, 1'b0, keys_in};
			PORT_KJOY:   dout = {3'b000, kj_in};
			PORT_KMOUSE: dout = mus_in;
			PORT_BE:     dout = portbe_mux;
			default:     dout = HIGH_IDLE;
		endcase
	end

endmodule

//--- logic/xt_regs.sv
/* Writes land one zclk after the port_wr strobe. tsconf, rompage, tgpage and fmaddr
   have no reset value and read as unknown until software loads them. */

`timescale 1ns/1ps

module xt_regs
	import zports_pkg::*;
(
	input  logic        zclk,
	input  logic        rst_n,
	input  logic        port_wr,
	input  logic        p7ffd_wr,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	output logic [7:0]  vconf,
	output logic [7:0]  tsconf,
	output offs_t       x_offs,
	output offs_t       y_offs,
	output logic [7:0]  border,
	output logic [47:0] xt_rampage,
	output logic [4:0]  xt_rompage,
	output logic [4:0]  tgpage,
	output logic [4:0]  fmaddr,
	output logic [3:0]  xt_override
);

	xt_idx_t hoa;
	logic portxt_wr, portfe_wr;
	logic rampage_h, rampages_h;
	page_t rampage [0:5];

	assign hoa       = a[15:8];
	assign portxt_wr = port_wr & (a[7:0] == PORT_XT);
	assign portfe_wr = port_wr & (a[7:0] == PORT_FE);

	assign rampage_h  = (hoa[7:2] == XT_RAMPAGE[7:2]);  // 4 windows
	assign rampages_h = (hoa[7:1] == XT_RAMPAGES[7:1]); // 2 shadow pages

	assign xt_rampage = {rampage[5], rampage[4], rampage[3], rampage[2], rampage[1], rampage[0]};

	//////////////////////////////
	// registers with reset
	//////////////////////////////

	always_ff @(posedge zclk)
		if (!rst_n)
		begin
			vconf  <= 8'h00;
			x_offs <= '0;
			y_offs <= '0;
			for (int i = 0; i < 6; i++)
				rampage[i] <= RAMPAGE_RST[i];
		end
		else if (portxt_wr)
		begin
			if (hoa == XT_VCONF)
				vconf <= din;
			if (hoa == XT_XOFFSL)
				x_offs[7:0] <= din;
			if (hoa == XT_XOFFSH)
				x_offs[8] <= din[0];
			if (hoa == XT_YOFFSL)
				y_offs[7:0] <= din;
			if (hoa == XT_YOFFSH)
				y_offs[8] <= din[0];
			if (rampage_h)
				rampage[{1'b0, a[9:8]}] <= din;
			if (rampages_h)
				rampage[{2'b10, a[8]}] <= din;
		end

	// an xt page write takes the window over from 7FFD
	always_ff @(posedge zclk)
		if (!rst_n)
			xt_override <= 4'b0000;
		else
		begin
			if (portxt_wr & rampage_h)
				xt_override[a[9:8]] <= 1'b1;
			if (portxt_wr & rampages_h)
				xt_override[{1'b1, a[8]}] <= 1'b1;
			if (p7ffd_wr)
				xt_override[3] <= 1'b0; // C000 window back to 7FFD
		end

	always_ff @(posedge zclk)
		if (!rst_n)
			border <= 8'h00;
		else if (portfe_wr)
			border <= {5'b11110, din[2:0]}; // spectrum colours at F0..F7
		else if (portxt_wr & (hoa == XT_BORDER))
			border <= din;

	//////////////////////////////
	// config without reset
	//////////////////////////////

	always_ff @(posedge zclk)
		if (portxt_wr)
		begin
			if (hoa == XT_TSCONF)
				tsconf <= din;
			if (hoa == XT_ROMPAGE)
				xt_rompage <= din[4:0];
			if (hoa == XT_FMADDR)
				fmaddr <= din[4:0];
			if (hoa == XT_TGPAGE)
				tgpage <= din[4:0];
		end

endmodule

//--- logic/mem_paging.sv
/* Pentagon-1M paging through 7FFD and EFF7. EFF7 bit 2 limits 7FFD to 128k and
   arms the lock, which holds until reset once 7FFD bit 5 has been set. */

`timescale 1ns/1ps

module mem_paging
	import zports_pkg::*;
(
	input  logic                   zclk,
	input  logic                   rst_n,
	input  logic                   port_wr,
	input  logic                   dos,
	input  logic [15:0]            a,
	input  logic [7:0]             din,
	input  logic [1:0]             rstrom,
	output logic [7:0]             p7ffd,
	output logic [7:0]             peff7,
	output logic [7:0]             vpage,
	output logic [PENT_PAGE_W-1:0] pent1m_page,
	output logic                   pent1m_rom,
	output logic                   pent1m_1m_on,
	output logic                   pent1m_ram0_0,
	output logic                   p7ffd_wr
);

	logic lock_7ffd;
	logic block1m;
	logic peff7_wr, xt_vpage_wr;

	assign block1m = peff7[2];

	assign p7ffd_wr    = port_wr & (a[7:0] == PORT_FD) & ~a[15] & ~lock_7ffd;
	assign peff7_wr    = port_wr & (a[7:0] == PORT_F7) & a[8] & ~a[12] & ~dos; // EFF7
	assign xt_vpage_wr = port_wr & (a[7:0] == PORT_XT) & (a[15:8] == XT_VPAGE);

	//////////////////////////////
	// 7FFD
	//////////////////////////////

	always_ff @(posedge zclk)
		if (!rst_n)
		begin
			p7ffd       <= 8'h00;
			lock_7ffd   <= 1'b0;
			vpage       <= VPAGE_RST;
			pent1m_page <= '0;
		end
		else if (p7ffd_wr)
		begin
			p7ffd       <= din;
			lock_7ffd   <= p7ffd[5] & block1m; // previous bit 5
			vpage       <= {6'b000001, din[3], 1'b1}; // screen 5 or 7
			pent1m_page <= {block1m ? 3'b000 : {din[5], din[7:6]}, din[2:0]};
		end
		else if (xt_vpage_wr)
			vpage <= din;

	always_ff @(posedge zclk)
		if (!rst_n)
			pent1m_rom <= rstrom[0]; // boot rom choice
		else if (p7ffd_wr)
			pent1m_rom <= din[4];

	//////////////////////////////
	// EFF7
	//////////////////////////////

	always_ff @(posedge zclk)
		if (!rst_n)
			peff7 <= 8'h00;
		else if (peff7_wr)
			peff7 <= din;

	assign pent1m_1m_on  = ~peff7[2];
	assign pent1m_ram0_0 = peff7[3]; // ram page 0 at 0000
endmodule

//--- logic/zports_top.sv
/* Z80-side port block on a single zclk domain. Outputs of xt_regs and
   mem_paging are plain registers; the read path is combinational. */

`timescale 1ns/1ps

module zports_top
	import zports_pkg::*;
(
	input  logic                   zclk,
	input  logic                   rst_n,
	input  logic                   iorq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	input  logic [15:0]            a,
	input  logic [7:0]             din,
	input  logic                   dos,
	input  logic                   tape_read,
	input  logic [4:0]             keys_in,
	input  logic [4:0]             kj_in,
	input  logic [7:0]             mus_in,
	input  logic [1:0]             rstrom,
	output logic                   port_wr,
	output logic                   port_rd,
	output logic                   porthit,
	output logic                   external_port,
	output logic                   dataout,
	output logic [7:0]             dout,
	output logic [7:0]             vconf,
	output logic [7:0]             tsconf,
	output offs_t                  x_offs,
	output offs_t                  y_offs,
	output logic [7:0]             border,
	output logic [47:0]            xt_rampage,
	output logic [4:0]             xt_rompage,
	output logic [4:0]             tgpage,
	output logic [4:0]             fmaddr,
	output logic [3:0]             xt_override,
	output logic [7:0]             p7ffd,
	output logic [7:0]             peff7,
	output logic [7:0]             vpage,
	output logic [PENT_PAGE_W-1:0] pent1m_page,
	output logic                   pent1m_rom,
	output logic                   pent1m_1m_on,
	output logic                   pent1m_ram0_0,
	output logic                   p7ffd_wr
);

	io_strobe u_strobe (
		.zclk    (zclk),
		.rst_n   (rst_n),
		.iorq_n  (iorq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.port_wr (port_wr),
		.port_rd (port_rd)
	);

	port_decode u_decode (
		.a             (a),
		.iorq_n        (iorq_n),
		.rd_n          (rd_n),
		.dos           (dos),
		.tape_read     (tape_read),
		.keys_in       (keys_in),
		.kj_in         (kj_in),
		.mus_in        (mus_in),
		.p7ffd         (p7ffd),
		.peff7         (peff7),
		.porthit       (porthit),
		.external_port (external_port),
		.dataout       (dataout),
		.dout          (dout)
	);

	xt_regs u_xt (
		.zclk        (zclk),
		.rst_n       (rst_n),
		.port_wr     (port_wr),
		.p7ffd_wr    (p7ffd_wr),
		.a           (a),
		.din         (din),
		.vconf       (vconf),
		.tsconf      (tsconf),
		.x_offs      (x_offs),
		.y_offs      (y_offs),
		.border      (border),
		.xt_rampage  (xt_rampage),
		.xt_rompage  (xt_rompage),
		.tgpage      (tgpage),
		.fmaddr      (fmaddr),
		.xt_override (xt_override)
	);

	mem_paging u_paging (
		.zclk          (zclk),
		.rst_n         (rst_n),
		.port_wr       (port_wr),
		.dos           (dos),
		.a             (a),
		.din           (din),
		.rstrom        (rstrom),
		.p7ffd         (p7ffd),
		.peff7         (peff7),
		.vpage         (vpage),
		.pent1m_page   (pent1m_page),
		.pent1m_rom    (pent1m_rom),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0),
		.p7ffd_wr      (p7ffd_wr)
	);

endmodule

//--- sim/zports_chk.sv
/* Bound into zports_top. Register rules are checked one cycle after the write strobe,
   while the Z80 still holds address and data on the bus. */

`timescale 1ns/1ps

module zports_chk
	import zports_pkg::*;
(
	input logic        zclk,
	input logic        rst_n,
	input logic        iorq_n,
	input logic        rd_n,
	input logic        wr_n,
	input logic [15:0] a,
	input logic [7:0]  din,
	input logic        dos,
	input logic        tape_read,
	input logic [4:0]  keys_in,
	input logic [4:0]  kj_in,
	input logic [7:0]  mus_in,
	input logic        port_wr,
	input logic        port_rd,
	input logic        porthit,
	input logic        external_port,
	input logic        dataout,
	input logic [7:0]  dout,
	input logic [7:0]  vconf,
	input logic [7:0]  tsconf,
	input offs_t       x_offs,
	input offs_t       y_offs,
	input logic [7:0]  border,
	input logic [47:0] xt_rampage,
	input logic [4:0]  xt_rompage,
	input logic [4:0]  tgpage,
	input logic [4:0]  fmaddr,
	input logic [3:0]  xt_override,
	input logic [7:0]  p7ffd,
	input logic [7:0]  peff7,
	input logic [7:0]  vpage,
	input logic [5:0]  pent1m_page,
	input logic        pent1m_rom,
	input logic        p7ffd_wr
);

	int fail_count = 0;

	xt_idx_t    hoa;
	logic       xt_wr, fd_wr, win_wr, shadow_wr, ay_sel;
	logic       lock_m, hit_exp;
	logic [7:0] dout_exp;
	logic [5:0] page_exp;
	page_t      pages [0:5];

	task automatic report_fail(input string what);
		fail_count++;
		$error("%s rule broken", what);
	endtask

	assign hoa       = a[15:8];
	assign xt_wr     = port_wr && a[7:0] == PORT_XT;
	assign fd_wr     = port_wr && a[7:0] == PORT_FD && !a[15]; // 7FFD request
	assign win_wr    = xt_wr && hoa >= XT_RAMPAGE && hoa <= XT_RAMPAGE + 8'd3;
	assign shadow_wr = xt_wr && (hoa == XT_RAMPAGES || hoa == XT_RAMPAGES + 8'd1);
	assign ay_sel    = a[7:0] == PORT_FD && a[15];
	assign page_exp  = peff7[2] ? {3'b000, din[2:0]} : {din[5], din[7:6], din[2:0]};

	always_comb
		for (int i = 0; i < 6; i++)
			pages[i] = xt_rampage[8*i +: 8];

	// decode expectations
	always_comb
	begin
		hit_exp  = 1'b0;
		dout_exp = HIGH_IDLE;
		if (a[7:0] inside {PORT_FE, PORT_XT, PORT_FD, PORT_BE, PORT_KMOUSE})
			hit_exp = 1'b1;
		if (a[7:0] inside {PORT_KJOY, PORT_F7})
			hit_exp = !dos; // hidden in shadow mode
		if (a[7:0] == PORT_FE)
			dout_exp = {1'b1, tape_read, 1'b0, keys_in};
		else if (a[7:0] == PORT_KJOY)
			dout_exp = {3'b000, kj_in};
		else if (a[7:0] == PORT_KMOUSE)
			dout_exp = mus_in;
		else if (a[7:0] == PORT_BE && a[11:8] == 4'hA)
			dout_exp = p7ffd;
		else if (a[7:0] == PORT_BE && a[11:8] == 4'hB)
			dout_exp = peff7;
	end

	// lock arms on a 7FFD write seen with old bit 5 and EFF7 bit 2 both set
	always_ff @(posedge zclk)
		if (!rst_n)
			lock_m <= 1'b0;
		else if (fd_wr && !lock_m)
			lock_m <= p7ffd[5] & peff7[2];

	//////////////////////////////
	// strobes
	//////////////////////////////

	a_wr_once: assert property (@(posedge zclk) disable iff (!rst_n)
		port_wr |=> !port_wr) else report_fail("port_wr width");
	a_rd_once: assert property (@(posedge zclk) disable iff (!rst_n)
		port_rd |=> !port_rd) else report_fail("port_rd width");
	a_wr_fire: assert property (@(posedge zclk) disable iff (!rst_n)
		!iorq_n && !wr_n && $past(iorq_n || wr_n) |=> port_wr) else report_fail("port_wr fire");
	a_rd_fire: assert property (@(posedge zclk) disable iff (!rst_n)
		!iorq_n && !rd_n && $past(iorq_n || rd_n) |=> port_rd) else report_fail("port_rd fire");
	a_wr_cause: assert property (@(posedge zclk) disable iff (!rst_n)
		port_wr |-> $past(!iorq_n && !wr_n) && $past(iorq_n || wr_n, 2))
		else report_fail("port_wr cause");
	a_rd_cause: assert property (@(posedge zclk) disable iff (!rst_n)
		port_rd |-> $past(!iorq_n && !rd_n) && $past(iorq_n || rd_n, 2))
		else report_fail("port_rd cause");

	//////////////////////////////
	// xxAF and border
	//////////////////////////////

	a_vconf: assert property (@(posedge zclk) disable iff (!rst_n)
		xt_wr && hoa == XT_VCONF |=> vconf == $past(din)) else report_fail("vconf");
	a_xoffs_l: assert property (@(posedge zclk) disable iff (!rst_n)
		xt_wr && hoa == XT_XOFFSL |=> x_offs[7:0] == $past(din)) else report_fail("x_offs low");
	a_xoffs_h: assert property (@(posedge zclk) disable iff (!rst_n)
		xt_wr && hoa == XT_XOFFSH |=> x_offs[8] == $past(din[0])) else report_fail("x_offs high");
	a_yoffs_l: assert property (@(posedge zclk) disable iff (!rst_n)
		xt_wr && hoa == XT_YOFFSL |=> y_offs[7:0] == $past(din)) else report_fail("y_offs low");
	a_yoffs_h: assert property (@(posedge zclk) disable iff (!rst_n)
		xt_wr && hoa == XT_YOFFSH |=> y_offs[8] == $past(din[0])) else report_fail("y_offs high");
	a_tsconf: assert property (@(posedge zclk) disable iff (!rst_n)
		xt_wr && hoa == XT_TSCONF |=> tsconf == $past(din)) else report_fail("tsconf");
	a_rompage: assert property (@(posedge zclk) disable iff (!rst_n)
		xt_wr && hoa == XT_ROMPAGE |=> xt_rompage == $past(din[4:0]))
		else report_fail("xt_rompage");
	a_fmaddr: assert property (@(posedge zclk) disable iff (!rst_n)
		xt_wr && hoa == XT_FMADDR |=> fmaddr == $past(din[4:0]))
		else report_fail("fmaddr");
	a_tgpage: assert property (@(posedge zclk) disable iff (!rst_n)
		xt_wr && hoa == XT_TGPAGE |=> tgpage == $past(din[4:0]))
		else report_fail("tgpage");
	a_border_xt: assert property (@(posedge zclk) disable iff (!rst_n)
		xt_wr && hoa == XT_BORDER |=> border == $past(din)) else report_fail("border xt");
	a_border_fe: assert property (@(posedge zclk) disable iff (!rst_n)
		port_wr && a[7:0] == PORT_FE |=> border == (8'hF0 | {5'b00000, $past(din[2:0])}))
		else report_fail("border fe");
	a_window: assert property (@(posedge zclk) disable iff (!rst_n)
		win_wr |=> pages[{1'b0, $past(a[9:8])}] == $past(din) && xt_override[$past(a[9:8])])
		else report_fail("ram window");
	a_shadow: assert property (@(posedge zclk) disable iff (!rst_n)
		shadow_wr |=> pages[{2'b10, $past(a[8])}] == $past(din)
		&& xt_override[{1'b1, $past(a[8])}]) else report_fail("shadow page");

	//////////////////////////////
	// paging
	//////////////////////////////

	a_vpage_xt: assert property (@(posedge zclk) disable iff (!rst_n)
		xt_wr && hoa == XT_VPAGE |=> vpage == $past(din)) else report_fail("vpage xt");
	a_7ffd_go: assert property (@(posedge zclk) disable iff (!rst_n)
		fd_wr && !lock_m |-> p7ffd_wr) else report_fail("7ffd strobe");
	a_7ffd_data: assert property (@(posedge zclk) disable iff (!rst_n)
		p7ffd_wr |=> p7ffd == $past(din) && !xt_override[3]) else report_fail("7ffd data");
	a_7ffd_page: assert property (@(posedge zclk) disable iff (!rst_n)
		p7ffd_wr |=> vpage == ($past(din[3]) ? 8'h07 : 8'h05) && pent1m_page == $past(page_exp))
		else report_fail("7ffd page");
	a_7ffd_rom: assert property (@(posedge zclk) disable iff (!rst_n)
		p7ffd_wr |=> pent1m_rom == $past(din[4])) else report_fail("7ffd rom");
	a_7ffd_lock: assert property (@(posedge zclk) disable iff (!rst_n)
		fd_wr && lock_m |=> p7ffd == $past(p7ffd)) else report_fail("7ffd lock");
	a_eff7: assert property (@(posedge zclk) disable iff (!rst_n)
		port_wr && a[7:0] == PORT_F7 && a[8] && !a[12] && !dos |=> peff7 == $past(din))
		else report_fail("eff7");

	//////////////////////////////
	// decode
	//////////////////////////////

	a_hit: assert property (@(posedge zclk) disable iff (!rst_n)
		porthit == hit_exp) else report_fail("porthit");
	a_ext: assert property (@(posedge zclk) disable iff (!rst_n)
		external_port == ay_sel) else report_fail("external_port");
	a_dataout: assert property (@(posedge zclk) disable iff (!rst_n)
		dataout == (hit_exp && !iorq_n && !rd_n && !ay_sel)) else report_fail("dataout");
	a_dout: assert property (@(posedge zclk) disable iff (!rst_n)
		dout == dout_exp) else report_fail("dout");

endmodule

bind zports_top zports_chk chk (.*);

//--- sim/zports_tb.sv
/* Z80 I/O cycles into zports_top; the rules are checked by the bound zports_chk.
   tsconf, rompage, tgpage and fmaddr have no reset value and are skipped after reset. */

`timescale 1ns/1ps

module zports_tb
	import zports_pkg::*;
();

	localparam int N_RAND  = 24;              // random AF writes, random reads
	localparam int N_IO    = 32 + 2 * N_RAND; // fixed cycles stay under 32
	localparam int TIMEOUT = 20 * N_IO;       // zclk cycles

	logic        zclk, rst_n, iorq_n, rd_n, wr_n, dos, tape_read;
	logic [15:0] a;
	logic [7:0]  din, mus_in;
	logic [4:0]  keys_in, kj_in;
	logic [1:0]  rstrom;
	logic        port_wr, port_rd, porthit, external_port, dataout;
	logic [7:0]  dout, vconf, tsconf, border, p7ffd, peff7, vpage;
	offs_t       x_offs, y_offs;
	logic [47:0] xt_rampage;
	logic [4:0]  xt_rompage, tgpage, fmaddr;
	logic [3:0]  xt_override;
	logic [PENT_PAGE_W-1:0] pent1m_page;
	logic        pent1m_rom, pent1m_1m_on, pent1m_ram0_0, p7ffd_wr;

	logic [31:0] seed = 32'd27444;
	int value_errors = 0;
	int io_count = 0;
	int cycles = 0;

	xt_idx_t fixed_idx [0:10] = '{XT_VCONF, XT_XOFFSL, XT_XOFFSH, XT_YOFFSL, XT_YOFFSH,
		XT_VPAGE, XT_BORDER, XT_TSCONF, XT_ROMPAGE, XT_FMADDR, XT_TGPAGE};
	port_t ports [0:7] = '{PORT_FE, PORT_XT, PORT_FD, PORT_BE, PORT_KJOY, PORT_KMOUSE,
		PORT_F7, 8'h55}; // last one is unassigned

	zports_top dut (.*);

	initial
	begin
		zclk = 1'b0;
		forever #10 zclk = ~zclk;
	end

	always @(posedge zclk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT)
		begin
			$display("timeout: stimulus still running after %0d cycles", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic logic [7:0] next_rand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[23:16];
	endfunction

	task automatic expect_val(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			value_errors++;
		end
	endtask

	// address first, request low for 3 cycles, then 2 idle
	task automatic io_cycle(input logic [15:0] adr, input logic [7:0] data,
			input logic write, input logic dos_v);
		logic [7:0] r;
		r = next_rand();
		@(posedge zclk);
		a         <= adr;
		din       <= data;
		dos       <= dos_v;
		keys_in   <= r[4:0];
		kj_in     <= r[7:3];
		tape_read <= r[5];
		mus_in    <= next_rand();
		@(posedge zclk);
		iorq_n <= 1'b0;
		if (write)
			wr_n <= 1'b0;
		else
			rd_n <= 1'b0;
		repeat (3) @(posedge zclk);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		repeat (2) @(posedge zclk);
		io_count++;
	endtask

	initial
	begin
		xt_idx_t hoa;
		logic [7:0] r;
		rst_n     = 1'b0;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		a         = 16'h0000;
		din       = 8'h00;
		dos       = 1'b0;
		tape_read = 1'b0;
		keys_in   = 5'h00;
		kj_in     = 5'h00;
		mus_in    = 8'h00;
		rstrom    = 2'b01; // boot rom bit 0 set
		repeat (3) @(posedge zclk);
		rst_n <= 1'b1;
		@(negedge zclk);

		//////////////////////////////
		// reset values
		//////////////////////////////
		expect_val("port_wr", 64'(port_wr), 64'h0);
		expect_val("port_rd", 64'(port_rd), 64'h0);
		expect_val("p7ffd_wr", 64'(p7ffd_wr), 64'h0);
		expect_val("vconf", 64'(vconf), 64'h0);
		expect_val("x_offs", 64'(x_offs), 64'h0);
		expect_val("y_offs", 64'(y_offs), 64'h0);
		expect_val("border", 64'(border), 64'h0);
		expect_val("xt_override", 64'(xt_override), 64'h0);
		expect_val("p7ffd", 64'(p7ffd), 64'h0);
		expect_val("peff7", 64'(peff7), 64'h0);
		expect_val("vpage", 64'(vpage), 64'h05);
		expect_val("xt_rampage", 64'(xt_rampage), 64'h0002_0002_0500); // pages 5..0
		expect_val("pent1m_page", 64'(pent1m_page), 64'h0);
		expect_val("pent1m_rom", 64'(pent1m_rom), 64'h1);
		expect_val("pent1m_1m_on", 64'(pent1m_1m_on), 64'h1);
		expect_val("pent1m_ram0_0", 64'(pent1m_ram0_0), 64'h0);

		//////////////////////////////
		// register writes
		//////////////////////////////
		for (int i = 0; i < 11; i++)
			io_cycle({fixed_idx[i], PORT_XT}, next_rand(), 1'b1, 1'b0);
		for (int i = 0; i < 4; i++)
			io_cycle({XT_RAMPAGE + 8'(i), PORT_XT}, next_rand(), 1'b1, 1'b0);
		for (int i = 0; i < 2; i++)
			io_cycle({XT_RAMPAGES + 8'(i), PORT_XT}, next_rand(), 1'b1, 1'b0);
		io_cycle({8'h00, PORT_FE}, next_rand(), 1'b1, 1'b0);
		io_cycle(16'h7FFD, next_rand() & 8'hDF, 1'b1, 1'b0); // flag 3 drops here
		for (int i = 0; i < N_RAND; i++)
		begin
			hoa = next_rand() % 8'd25; // indices 00..18
			io_cycle({hoa, PORT_XT}, next_rand(), 1'b1, 1'b0);
		end

		//////////////////////////////
		// decode and read-back
		//////////////////////////////
		for (int i = 0; i < N_RAND; i++)
		begin
			r = next_rand();
			io_cycle({next_rand(), ports[r[2:0]]}, 8'h00, 1'b0, r[7]);
		end
		io_cycle(16'hFFFD, 8'h00, 1'b0, 1'b0); // AY read stays external

		// 128k mode, then arm and hit the lock
		io_cycle(16'hEFF7, next_rand() | 8'h04, 1'b1, 1'b0);
		io_cycle(16'h0BBE, 8'h00, 1'b0, 1'b0);
		io_cycle(16'h7FFD, next_rand() | 8'h20, 1'b1, 1'b0);
		io_cycle(16'h7FFD, next_rand() | 8'h20, 1'b1, 1'b0);
		io_cycle(16'h7FFD, next_rand(), 1'b1, 1'b0);
		io_cycle(16'h0ABE, 8'h00, 1'b0, 1'b1);

		repeat (3) @(posedge zclk);
		$display("errors: %0d value, %0d assertion, over %0d I/O cycles",
			value_errors, dut.chk.fail_count, io_count);
		if (value_errors == 0 && dut.chk.fail_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- src.f
logic/zports_pkg.sv
logic/io_strobe.sv
logic/port_decode.sv
logic/xt_regs.sv
logic/mem_paging.sv
logic/zports_top.sv
sim/zports_chk.sv
sim/zports_tb.sv

//--- Makefile
TOP = zports_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o zports_sim
	@out="$$(./obj_dir/zports_sim +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
